//--- Makefile
SRCS := $(shell cat compile.f)

.PHONY: run clean

run: obj_dir/Vtb_alu_exec
	@out=$$(./obj_dir/Vtb_alu_exec); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

obj_dir/Vtb_alu_exec: compile.f $(SRCS)
	verilator --binary --timing --top-module tb_alu_exec -f compile.f

clean:
	rm -rf obj_dir

//--- alu_core.sv
`timescale 1ns/1ps

module alu_core (
  input  logic   clk_i,
  input  logic   rst_n_i,
  alu_req_if.dst req,
  alu_rsp_if.src rsp
);
  import alu_pkg::*;

  logic                   is_cmp;
  logic                   is_sub;
  logic [XLEN:0]          add_a;
  logic [XLEN:0]          add_b;
  logic [XLEN:0]          add_out;
  logic                   sf;
  logic                   of;
  logic                   lt;
  logic                   ltu;
  logic                   eq;
  logic                   cmp_bit;
  logic                   mul_a_signed;
  logic                   mul_b_signed;
  logic signed [XLEN:0]   mul_a;
  logic signed [XLEN:0]   mul_b;
  logic signed [2*XLEN+1:0] prod;
  alu_data_t              shift_out;
  alu_data_t              result_d;

  // decode
  assign is_cmp = req.op inside {ALU_OP_SLT, ALU_OP_SLTU, ALU_OP_BEQ, ALU_OP_BNE,
                                 ALU_OP_BLT, ALU_OP_BGE, ALU_OP_BLTU, ALU_OP_BGEU};
  assign is_sub = (req.op == ALU_OP_SUB) || is_cmp;  // compares subtract too

  // shared adder with double sign bit
  assign add_a   = {req.a[XLEN-1], req.a};
  assign add_b   = {req.b[XLEN-1], req.b} ^ {(XLEN + 1){is_sub}};  // invert for sub
  assign add_out = add_a + add_b + {{XLEN{1'b0}}, is_sub};

  assign sf  = add_out[XLEN-1];
  assign of  = add_out[XLEN] ^ add_out[XLEN-1];  // sign bits disagree
  assign lt  = sf ^ of;
  // unsigned order flips when the operand signs differ
  assign ltu = lt ^ req.a[XLEN-1] ^ req.b[XLEN-1];
  assign eq  = (add_out[XLEN-1:0] == '0);

  always_comb begin
    case (req.op)
      ALU_OP_SLT, ALU_OP_BLT:   cmp_bit = lt;
      ALU_OP_SLTU, ALU_OP_BLTU: cmp_bit = ltu;
      ALU_OP_BEQ:               cmp_bit = eq;
      ALU_OP_BNE:               cmp_bit = ~eq;
      ALU_OP_BGE:               cmp_bit = ~lt;
      ALU_OP_BGEU:              cmp_bit = ~ltu;
      default:                  cmp_bit = 1'b0;
    endcase
  end

  alu_shift u_shift (
    .shift_op_i    (req.op),
    .shift_num_i   (req.a),
    .shift_count_i (req.b[5:0]),
    .shift_out_o   (shift_out)
  );

  // multiplier, operands widened by one bit to pick signed or unsigned
  assign mul_a_signed = req.op inside {ALU_OP_MUL, ALU_OP_MULH, ALU_OP_MULHSU, ALU_OP_MULW};
  assign mul_b_signed = req.op inside {ALU_OP_MUL, ALU_OP_MULH, ALU_OP_MULW};
  assign mul_a = {mul_a_signed & req.a[XLEN-1], req.a};
  assign mul_b = {mul_b_signed & req.b[XLEN-1], req.b};
  assign prod  = mul_a * mul_b;  // only the low 128 bits matter

  // result mux
  always_comb begin
    case (req.op)
      ALU_OP_ADD, ALU_OP_SUB: result_d = add_out[XLEN-1:0];
      ALU_OP_AND:             result_d = req.a & req.b;
      ALU_OP_OR:              result_d = req.a | req.b;
      ALU_OP_XOR:             result_d = req.a ^ req.b;
      ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA,
      ALU_OP_SLLW, ALU_OP_SRLW, ALU_OP_SRAW: begin
        result_d = shift_out;
      end
      ALU_OP_MUL:             result_d = prod[XLEN-1:0];
      ALU_OP_MULH, ALU_OP_MULHSU, ALU_OP_MULHU: begin
        result_d = prod[2*XLEN-1:XLEN];  // high half
      end
      ALU_OP_MULW:            result_d = {{32{prod[31]}}, prod[31:0]};
      default:                result_d = {{(XLEN - 1){1'b0}}, cmp_bit};  // compares
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp.valid <= 1'b0;
    end else begin
      rsp.valid <= req.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.valid) begin
      rsp.result <= result_d;
      rsp.cmp    <= cmp_bit;
      rsp.tag    <= req.tag;
    end
  end

endmodule

//--- alu_exec_top.sv
`timescale 1ns/1ps

module alu_exec_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // upstream, issue side
  input  logic               in_valid_i,
  input  alu_pkg::alu_op_e   in_op_i,
  input  alu_pkg::alu_data_t in_a_i,
  input  alu_pkg::alu_data_t in_b_i,
  input  alu_pkg::alu_tag_t  in_tag_i,
  output logic               in_credit_o,
  // downstream, writeback side
  input  logic               out_credit_i,
  output logic               out_valid_o,
  output alu_pkg::alu_data_t out_result_o,
  output logic               out_cmp_o,
  output alu_pkg::alu_tag_t  out_tag_o
);

  logic slot_free;  // result slot credit back to the issue side

  alu_req_if req_if ();
  alu_rsp_if rsp_if ();

  alu_issue_buf u_issue_buf (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_op_i     (in_op_i),
    .in_a_i      (in_a_i),
    .in_b_i      (in_b_i),
    .in_tag_i    (in_tag_i),
    .in_credit_o (in_credit_o),
    .slot_free_i (slot_free),
    .req         (req_if.src)
  );

  alu_core u_core (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req     (req_if.dst),
    .rsp     (rsp_if.src)
  );

  alu_result_buf u_result_buf (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rsp          (rsp_if.dst),
    .slot_free_o  (slot_free),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_cmp_o    (out_cmp_o),
    .out_tag_o    (out_tag_o)
  );

endmodule

//--- alu_if.sv
`timescale 1ns/1ps

// issue buffer to core, no ready: sender holds a result slot credit
interface alu_req_if;
  import alu_pkg::*;

  logic      valid;  // taken on every cycle it is high
  alu_op_e   op;
  alu_data_t a;
  alu_data_t b;
  alu_tag_t  tag;

  modport src (output valid, output op, output a, output b, output tag);
  modport dst (input valid, input op, input a, input b, input tag);

endinterface

// core to result buffer
interface alu_rsp_if;
  import alu_pkg::*;

  logic      valid;
  alu_data_t result;
  logic      cmp;    // compare bit, zero for non-compare ops
  alu_tag_t  tag;

  modport src (output valid, output result, output cmp, output tag);
  modport dst (input valid, input result, input cmp, input tag);

endinterface

//--- alu_issue_buf.sv
`timescale 1ns/1ps

module alu_issue_buf (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  alu_pkg::alu_op_e   in_op_i,
  input  alu_pkg::alu_data_t in_a_i,
  input  alu_pkg::alu_data_t in_b_i,
  input  alu_pkg::alu_tag_t  in_tag_i,
  output logic               in_credit_o,
  input  logic               slot_free_i,
  alu_req_if.src             req
);
  import alu_pkg::*;

  localparam int PTR_W = $clog2(ISSUE_DEPTH);
  localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);
  localparam int SLOT_W = $clog2(RESULT_DEPTH + 1);

  alu_op_e   op_q  [ISSUE_DEPTH];
  alu_data_t a_q   [ISSUE_DEPTH];
  alu_data_t b_q   [ISSUE_DEPTH];
  alu_tag_t  tag_q [ISSUE_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;     // entries held
  logic [SLOT_W-1:0] slot_cnt;  // free result buffer slots
  logic              pop;

  // head goes out only against a result slot
  assign pop = (count != '0) && (slot_cnt != '0);

  // queue storage
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      op_q[wr_ptr]  <= in_op_i;
      a_q[wr_ptr]   <= in_a_i;
      b_q[wr_ptr]   <= in_b_i;
      tag_q[wr_ptr] <= in_tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      slot_cnt <= SLOT_W'(RESULT_DEPTH);
    end else begin
      if (in_valid_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count + CNT_W'(in_valid_i) - CNT_W'(pop);
      slot_cnt <= slot_cnt + SLOT_W'(slot_free_i) - SLOT_W'(pop);
    end
  end

  assign req.valid = pop;
  assign req.op    = op_q[rd_ptr];
  assign req.a     = a_q[rd_ptr];
  assign req.b     = b_q[rd_ptr];
  assign req.tag   = tag_q[rd_ptr];

  assign in_credit_o = pop;  // freed entry goes back upstream

endmodule

//--- alu_pkg.sv
package alu_pkg;

  localparam int XLEN = 64;          // data width
  localparam int ISSUE_DEPTH = 4;    // also the upstream credit count at reset
  localparam int RESULT_DEPTH = 4;

  typedef logic [XLEN-1:0] alu_data_t;

  // sequence tag, follows each request through the unit
  typedef logic [3:0] alu_tag_t;

  // encoding matches the op column of the stimulus file
  typedef enum logic [4:0] {
    ALU_OP_ADD    = 5'd0,
    ALU_OP_SUB    = 5'd1,
    ALU_OP_AND    = 5'd2,
    ALU_OP_OR     = 5'd3,
    ALU_OP_XOR    = 5'd4,
    // shifts
    ALU_OP_SLL    = 5'd5,
    ALU_OP_SRL    = 5'd6,
    ALU_OP_SRA    = 5'd7,
    ALU_OP_SLLW   = 5'd8,
    ALU_OP_SRLW   = 5'd9,
    ALU_OP_SRAW   = 5'd10,
    // set-less-than
    ALU_OP_SLT    = 5'd11,
    ALU_OP_SLTU   = 5'd12,
    // branch compares
    ALU_OP_BEQ    = 5'd13,
    ALU_OP_BNE    = 5'd14,
    ALU_OP_BLT    = 5'd15,
    ALU_OP_BGE    = 5'd16,
    ALU_OP_BLTU   = 5'd17,
    ALU_OP_BGEU   = 5'd18,
    // multiplies
    ALU_OP_MUL    = 5'd19,
    ALU_OP_MULH   = 5'd20,
    ALU_OP_MULHSU = 5'd21,
    ALU_OP_MULHU  = 5'd22,
    ALU_OP_MULW   = 5'd23
  } alu_op_e;

endpackage

//--- alu_result_buf.sv
`timescale 1ns/1ps

module alu_result_buf (
  input  logic               clk_i,
  input  logic               rst_n_i,
  alu_rsp_if.dst             rsp,
  output logic               slot_free_o,
  input  logic               out_credit_i,
  output logic               out_valid_o,
  output alu_pkg::alu_data_t out_result_o,
  output logic               out_cmp_o,
  output alu_pkg::alu_tag_t  out_tag_o
);
  import alu_pkg::*;

  localparam int PTR_W = $clog2(RESULT_DEPTH);
  localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

  alu_data_t         res_q [RESULT_DEPTH];
  logic [RESULT_DEPTH-1:0] cmp_q;
  alu_tag_t          tag_q [RESULT_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] credit_cnt;  // writeback credits in hand
  logic             pop;

  assign pop = (count != '0) && (credit_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (rsp.valid) begin
      res_q[wr_ptr] <= rsp.result;
      cmp_q[wr_ptr] <= rsp.cmp;
      tag_q[wr_ptr] <= rsp.tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      credit_cnt  <= CNT_W'(RESULT_DEPTH);
      out_valid_o <= 1'b0;
    end else begin
      if (rsp.valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count       <= count + CNT_W'(rsp.valid) - CNT_W'(pop);
      credit_cnt  <= credit_cnt + CNT_W'(out_credit_i) - CNT_W'(pop);
      out_valid_o <= pop;  // one credit spent per result shown
    end
  end

  // output register, head loaded as it leaves the queue
  always_ff @(posedge clk_i) begin
    if (pop) begin
      out_result_o <= res_q[rd_ptr];
      out_cmp_o    <= cmp_q[rd_ptr];
      out_tag_o    <= tag_q[rd_ptr];
    end
  end

  // a slot frees in the same cycle its result is presented
  assign slot_free_o = out_valid_o;

endmodule

//--- alu_shift.sv
`timescale 1ns/1ps

module alu_shift (
  input  alu_pkg::alu_op_e   shift_op_i,
  input  alu_pkg::alu_data_t shift_num_i,
  input  logic [5:0]         shift_count_i,
  output alu_pkg::alu_data_t shift_out_o
);
  import alu_pkg::*;

  logic        is_w;      // 32-bit form
  logic [31:0] num_w;
  logic [4:0]  count_w;
  logic [31:0] res_w;
  alu_data_t   res_d;

  assign is_w    = shift_op_i inside {ALU_OP_SLLW, ALU_OP_SRLW, ALU_OP_SRAW};
  assign num_w   = shift_num_i[31:0];    // upper word ignored for W forms
  assign count_w = shift_count_i[4:0];

  always_comb begin
    res_d = '0;
    res_w = '0;
    case (shift_op_i)
      ALU_OP_SLL:  res_d = shift_num_i << shift_count_i;
      ALU_OP_SRL:  res_d = shift_num_i >> shift_count_i;
      ALU_OP_SRA:  res_d = $signed(shift_num_i) >>> shift_count_i;
      ALU_OP_SLLW: res_w = num_w << count_w;
      ALU_OP_SRLW: res_w = num_w >> count_w;
      ALU_OP_SRAW: res_w = $signed(num_w) >>> count_w;  // fills from bit 31
      default:     res_d = '0;
    endcase
  end

  // W results sign-extended from bit 31
  assign shift_out_o = is_w ? {{32{res_w[31]}}, res_w} : res_d;

endmodule

//--- compile.f
alu_pkg.sv
alu_if.sv
alu_issue_buf.sv
alu_shift.sv
alu_core.sv
alu_result_buf.sv
alu_exec_top.sv
tb_alu_exec.sv

//--- tb_alu_exec.sv
`timescale 1ns/1ps

module tb_alu_exec;
  import alu_pkg::*;

  localparam int WAIT_LIMIT = 300;  // cycles allowed per wait loop
  localparam int HOLD_PCT   = 60;   // chance writeback sits on a credit

  typedef struct packed {
    alu_data_t res;
    logic      cmp;
    alu_tag_t  tag;
  } expect_t;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      in_valid_i;
  alu_op_e   in_op_i;
  alu_data_t in_a_i;
  alu_data_t in_b_i;
  alu_tag_t  in_tag_i;
  logic      in_credit_o;
  logic      out_credit_i;
  logic      out_valid_o;
  alu_data_t out_result_o;
  logic      out_cmp_o;
  alu_tag_t  out_tag_o;

  // outstanding requests, oldest first
  expect_t exp_q [$];
  string   name_q [$];

  int       up_credits = ISSUE_DEPTH;
  int       owed_credits = 0;  // results taken, credit not handed back yet
  int       sent_cnt = 0;
  int       seen_cnt = 0;
  int       pulse_cnt = 0;
  int       mismatch_cnt = 0;
  int       other_cnt = 0;
  bit       timed_out = 1'b0;
  alu_tag_t next_tag = '0;

  alu_exec_top i_dut (.*);

  always #20 clk_i = ~clk_i;

  task automatic check_result(input string name, input alu_data_t exp, input alu_data_t act);
    if (exp !== act) begin
      $display("mismatch %s result: expected %h, actual %h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_cmp(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s cmp: expected %b, actual %b", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_tag(input string name, input alu_tag_t exp, input alu_tag_t act);
    if (exp !== act) begin
      $display("mismatch %s tag: expected %0d, actual %0d", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  // upstream credits and writeback side, sampled mid-cycle
  always @(negedge clk_i) begin
    expect_t e;
    string   name;
    if (rst_n_i) begin
      if (in_credit_o) begin
        up_credits++;
        pulse_cnt++;
      end
      if (out_valid_o) begin
        seen_cnt++;
        owed_credits++;
        if (exp_q.size() == 0) begin
          $display("result with tag %0d came out with no request outstanding", out_tag_o);
          other_cnt++;
        end else begin
          e    = exp_q.pop_front();
          name = name_q.pop_front();
          check_result(name, e.res, out_result_o);
          check_cmp(name, e.cmp, out_cmp_o);
          check_tag(name, e.tag, out_tag_o);
        end
      end
    end
  end

  // move to just after the next rising edge
  task automatic advance(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
      if (owed_credits > 0 && ($urandom % 100) >= HOLD_PCT) begin
        out_credit_i = 1'b1;
        owed_credits--;
      end else begin
        out_credit_i = 1'b0;  // credit withheld this cycle
      end
    end
  endtask

  task automatic send_request(input int idx, input alu_op_e op, input alu_data_t a,
                              input alu_data_t b, input alu_data_t res, input logic cmp);
    int waited;
    waited = 0;
    while (up_credits == 0 && waited < WAIT_LIMIT) begin
      advance(1);
      waited++;
    end
    if (up_credits == 0) begin
      $display("timeout: no issue credit came back for vector %0d", idx);
      other_cnt++;
      timed_out = 1'b1;
    end else begin
      in_valid_i = 1'b1;
      in_op_i    = op;
      in_a_i     = a;
      in_b_i     = b;
      in_tag_i   = next_tag;
      exp_q.push_back('{res, cmp, next_tag});
      name_q.push_back($sformatf("vec %0d %s", idx, op.name()));
      next_tag++;
      up_credits--;
      sent_cnt++;
      advance(1);
      in_valid_i = 1'b0;
    end
  endtask

  initial begin
    int         fd;
    int         vec_idx;
    int         waited;
    string      line;
    logic [7:0] op_v;
    alu_data_t  a_v;
    alu_data_t  b_v;
    alu_data_t  r_v;
    logic [7:0] c_v;
    rst_n_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_op_i      = ALU_OP_ADD;
    in_a_i       = '0;
    in_b_i       = '0;
    in_tag_i     = '0;
    out_credit_i = 1'b0;
    vec_idx      = 0;
    void'($urandom(32'h1c03_6ad3));
    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    fd = $fopen("tb_alu_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tb_alu_input.txt");
      other_cnt++;
    end else begin
      while (!timed_out && $fgets(line, fd) > 0) begin
        if (line.getc(0) != "#" &&
            $sscanf(line, "%h %h %h %h %h", op_v, a_v, b_v, r_v, c_v) == 5) begin
          advance($urandom % 3);  // random gap
          send_request(vec_idx, alu_op_e'(op_v[4:0]), a_v, b_v, r_v, c_v[0]);
          vec_idx++;
        end
      end
      $fclose(fd);
      if (vec_idx == 0) begin
        $display("the stimulus file held no vectors");
        other_cnt++;
      end
    end

    // drain, then make sure nothing extra follows
    if (!timed_out) begin
      waited = 0;
      while (seen_cnt < sent_cnt && waited < WAIT_LIMIT) begin
        advance(1);
        waited++;
      end
      advance(8);
      if (seen_cnt < sent_cnt) begin
        $display("timeout: only %0d of %0d results came out", seen_cnt, sent_cnt);
        other_cnt++;
      end
      if (pulse_cnt != sent_cnt) begin
        $display("mismatch issue credit pulses: expected %0d, actual %0d", sent_cnt, pulse_cnt);
        mismatch_cnt++;
      end
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tb_alu_input.txt
# columns in hex: op a b expected_result expected_cmp
# op follows alu_op_e, 00 add through 17 mulw
00 7fffffffffffffff 0000000000000001 8000000000000000 0
01 0000000000000000 0000000000000001 ffffffffffffffff 0
02 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 0
03 f0f0f0f0f0f0f0f0 0f0f0f0f00000000 fffffffff0f0f0f0 0
04 aaaaaaaaaaaaaaaa ffffffff00000000 55555555aaaaaaaa 0
05 0000000000000001 000000000000003f 8000000000000000 0
06 8000000000000000 000000000000003f 0000000000000001 0
07 8000000000000000 0000000000000004 f800000000000000 0
07 ff00000000000000 000000000000003f ffffffffffffffff 0
08 ffffffff40000000 0000000000000021 ffffffff80000000 0
09 ffffffff80000010 0000000000000004 0000000008000001 0
0a 0000000080000000 0000000000000004 fffffffff8000000 0
0b ffffffffffffffff 0000000000000001 0000000000000001 1
0c ffffffffffffffff 0000000000000001 0000000000000000 0
0d 5555555555555555 5555555555555555 0000000000000001 1
0e 5555555555555555 5555555555555555 0000000000000000 0
0f 8000000000000000 7fffffffffffffff 0000000000000001 1
10 0000000000000000 ffffffffffffffff 0000000000000001 1
11 0000000000000000 ffffffffffffffff 0000000000000001 1
12 8000000000000000 7fffffffffffffff 0000000000000001 1
13 0000000000000003 0000000000000005 000000000000000f 0
14 8000000000000000 8000000000000000 4000000000000000 0
15 ffffffffffffffff 0000000000000002 ffffffffffffffff 0
16 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0
17 0000000000000007 fffffffffffffffd ffffffffffffffeb 0
